//--- logic/core_pkg.sv
// ----------------------------------------
// core package
// word types, ALU operations and the
// RV32I encodings the mini core decodes
// ----------------------------------------

`default_nettype none

package core_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int unsigned Xlen   = 32;
  localparam int unsigned NrRegs = 32;

  typedef logic [Xlen-1:0]           xlen_t;
  typedef logic [$clog2(NrRegs)-1:0] reg_addr_t;

  // ----------------------------------------
  // operations
  // ----------------------------------------
  // addi shares OP_ADD, the immediate is picked as operand b
  typedef enum logic [3:0] {
    OP_ADD     = 4'd0,
    OP_SUB     = 4'd1,
    OP_AND     = 4'd2,
    OP_OR      = 4'd3,
    OP_XOR     = 4'd4,
    OP_SLL     = 4'd5,
    OP_SRL     = 4'd6,
    OP_LUI     = 4'd7,
    OP_ILLEGAL = 4'd15
  } alu_op_e;

  // ----------------------------------------
  // encodings
  // ----------------------------------------
  // major opcodes
  localparam logic [6:0] OpcodeOp    = 7'b0110011;
  localparam logic [6:0] OpcodeOpImm = 7'b0010011;
  localparam logic [6:0] OpcodeLui   = 7'b0110111;

  // funct7 of sub (and sra, which is not supported)
  localparam logic [6:0] Funct7Alt   = 7'b0100000;

endpackage

`default_nettype wire

//--- logic/fetch_queue.sv
// ----------------------------------------
// fetch queue
// instruction FIFO in front of decode,
// hands back one credit per released entry
// ----------------------------------------

`timescale 1ns/10ps
`default_nettype none

module fetch_queue import core_pkg::*; #(
  parameter int unsigned FetchDepth = 4
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  instr_valid_i,
  input  xlen_t instr_i,
  input  logic  pop_i,
  output logic  head_valid_o,
  output xlen_t head_instr_o,
  output logic  credit_o
);

  localparam int unsigned PtrW = (FetchDepth > 1) ? $clog2(FetchDepth) : 1;
  localparam int unsigned CntW = $clog2(FetchDepth + 1);

  xlen_t           mem_q [FetchDepth];
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_q;
  logic [CntW-1:0] count_q;
  logic            credit_q;
  logic            push;
  logic            pop;

  assign push         = instr_valid_i;
  assign pop          = pop_i & head_valid_o;
  assign head_valid_o = (count_q != '0);
  assign head_instr_o = mem_q[rd_ptr_q];
  assign credit_o     = credit_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(FetchDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(FetchDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + CntW'(push) - CntW'(pop);
      // freed slot goes back to the producer next cycle
      credit_q <= pop;
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= instr_i;
    end
  end

  // producer ran out of credits but sent anyway
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> (count_q != CntW'(FetchDepth)));

  // decode must only take an entry that is there
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> head_valid_o);

endmodule

`default_nettype wire

//--- logic/id_stage.sv
// ----------------------------------------
// decode stage
// turns the queue head into an ALU op,
// register indices and an immediate
// ----------------------------------------

`timescale 1ns/10ps
`default_nettype none

module id_stage import core_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      head_valid_i,
  input  xlen_t     head_instr_i,
  output logic      pop_o,
  output logic      id_valid_o,
  output alu_op_e   id_op_o,
  output reg_addr_t id_rd_o,
  output reg_addr_t id_rs1_o,
  output reg_addr_t id_rs2_o,
  output xlen_t     id_imm_o,
  output logic      id_use_imm_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_op_e    op_d;
  xlen_t      imm_d;
  logic       use_imm_d;
  logic       valid_q;

  assign opcode = head_instr_i[6:0];
  assign funct3 = head_instr_i[14:12];
  assign funct7 = head_instr_i[31:25];

  // nothing stalls, so the head is always taken
  assign pop_o = head_valid_i;

  always_comb begin
    op_d      = OP_ILLEGAL;
    imm_d     = '0;
    use_imm_d = 1'b0;
    case (opcode)
      OpcodeOp: begin
        if (funct7 == 7'b0) begin
          case (funct3)
            3'b000:  op_d = OP_ADD;
            3'b001:  op_d = OP_SLL;
            3'b100:  op_d = OP_XOR;
            3'b101:  op_d = OP_SRL;
            3'b110:  op_d = OP_OR;
            3'b111:  op_d = OP_AND;
            // slt and sltu are not in the subset
            default: op_d = OP_ILLEGAL;
          endcase
        end else if ((funct7 == Funct7Alt) && (funct3 == 3'b000)) begin
          op_d = OP_SUB;
        end
      end
      OpcodeOpImm: begin
        // only addi
        imm_d     = {{20{head_instr_i[31]}}, head_instr_i[31:20]};
        use_imm_d = 1'b1;
        if (funct3 == 3'b000) begin
          op_d = OP_ADD;
        end
      end
      OpcodeLui: begin
        imm_d     = {head_instr_i[31:12], 12'b0};
        use_imm_d = 1'b1;
        op_d      = OP_LUI;
      end
      default: op_d = OP_ILLEGAL;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= head_valid_i;
    end
  end

  // decoded fields, rd zeroed for illegal words so nothing gets written
  always_ff @(posedge clk_i) begin
    id_op_o      <= op_d;
    id_rd_o      <= (op_d == OP_ILLEGAL) ? '0 : head_instr_i[11:7];
    id_rs1_o     <= head_instr_i[19:15];
    id_rs2_o     <= head_instr_i[24:20];
    id_imm_o     <= imm_d;
    id_use_imm_o <= use_imm_d;
  end

  assign id_valid_o = valid_q;

endmodule

`default_nettype wire

//--- logic/regfile.sv
// ----------------------------------------
// integer register file
// 32 x 32, two async reads, one write,
// x0 hardwired to zero
// ----------------------------------------

`timescale 1ns/10ps
`default_nettype none

module regfile import core_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  output xlen_t     rdata_a_o,
  output xlen_t     rdata_b_o,
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  xlen_t     wdata_i
);

  xlen_t regs_q [NrRegs];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NrRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // read ports
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

//--- logic/ex_stage.sv
// ----------------------------------------
// execute stage
// operand select with bypass, ALU and the
// result register feeding commit
// ----------------------------------------

`timescale 1ns/10ps
`default_nettype none

module ex_stage import core_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      id_valid_i,
  input  alu_op_e   id_op_i,
  input  reg_addr_t id_rd_i,
  input  reg_addr_t id_rs1_i,
  input  reg_addr_t id_rs2_i,
  input  xlen_t     id_imm_i,
  input  logic      id_use_imm_i,
  output reg_addr_t raddr_a_o,
  output reg_addr_t raddr_b_o,
  input  xlen_t     rdata_a_i,
  input  xlen_t     rdata_b_i,
  output logic      res_valid_o,
  output reg_addr_t res_rd_o,
  output xlen_t     res_data_o,
  output logic      res_illegal_o
);

  logic      res_valid_q;
  logic      res_illegal_q;
  reg_addr_t res_rd_q;
  xlen_t     res_data_q;
  logic      bypass_a;
  logic      bypass_b;
  xlen_t     operand_a;
  xlen_t     operand_b;
  xlen_t     alu_result;

  assign raddr_a_o = id_rs1_i;
  assign raddr_b_o = id_rs2_i;

  // ----------------------------------------
  // operands
  // ----------------------------------------
  // result register is written back only at the next edge
  assign bypass_a = res_valid_q && (res_rd_q == id_rs1_i) && (id_rs1_i != '0);
  assign bypass_b = res_valid_q && (res_rd_q == id_rs2_i) && (id_rs2_i != '0);

  assign operand_a = bypass_a ? res_data_q : rdata_a_i;
  assign operand_b = id_use_imm_i ? id_imm_i :
                     bypass_b     ? res_data_q : rdata_b_i;

  // ----------------------------------------
  // ALU
  // ----------------------------------------
  always_comb begin
    case (id_op_i)
      OP_ADD:  alu_result = operand_a + operand_b;
      OP_SUB:  alu_result = operand_a - operand_b;
      OP_AND:  alu_result = operand_a & operand_b;
      OP_OR:   alu_result = operand_a | operand_b;
      OP_XOR:  alu_result = operand_a ^ operand_b;
      OP_SLL:  alu_result = operand_a << operand_b[4:0];
      OP_SRL:  alu_result = operand_a >> operand_b[4:0];
      OP_LUI:  alu_result = id_imm_i;
      default: alu_result = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q   <= 1'b0;
      res_illegal_q <= 1'b0;
    end else begin
      res_valid_q   <= id_valid_i;
      res_illegal_q <= id_valid_i && (id_op_i == OP_ILLEGAL);
    end
  end

  always_ff @(posedge clk_i) begin
    res_rd_q   <= id_rd_i;
    res_data_q <= alu_result;
  end

  assign res_valid_o   = res_valid_q;
  assign res_rd_o      = res_rd_q;
  assign res_data_o    = res_data_q;
  assign res_illegal_o = res_illegal_q;

  // decoder clears rd on illegal words, so they never reach a register
  a_illegal_no_rd : assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_illegal_o |-> (res_rd_o == '0));

endmodule

`default_nettype wire

//--- logic/commit_stage.sv
// ----------------------------------------
// commit stage
// write-back, commit port and the retired
// and illegal instruction counters
// ----------------------------------------

`timescale 1ns/10ps
`default_nettype none

module commit_stage import core_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      res_valid_i,
  input  reg_addr_t res_rd_i,
  input  xlen_t     res_data_i,
  input  logic      res_illegal_i,
  output logic      we_o,
  output reg_addr_t waddr_o,
  output xlen_t     wdata_o,
  output logic      commit_valid_o,
  output reg_addr_t commit_rd_o,
  output xlen_t     commit_data_o,
  output logic      commit_illegal_o,
  output xlen_t     instret_o,
  output xlen_t     illegal_cnt_o
);

  xlen_t instret_q;
  xlen_t illegal_cnt_q;

  // write-back lands at the next edge
  assign we_o    = res_valid_i && !res_illegal_i && (res_rd_i != '0);
  assign waddr_o = res_rd_i;
  assign wdata_o = res_data_i;

  // every word retires here, in order
  assign commit_valid_o   = res_valid_i;
  assign commit_rd_o      = res_rd_i;
  assign commit_data_o    = res_data_i;
  assign commit_illegal_o = res_illegal_i;

  // performance counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instret_q     <= '0;
      illegal_cnt_q <= '0;
    end else if (res_valid_i) begin
      instret_q <= instret_q + 1'b1;
      if (res_illegal_i) begin
        illegal_cnt_q <= illegal_cnt_q + 1'b1;
      end
    end
  end

  assign instret_o     = instret_q;
  assign illegal_cnt_o = illegal_cnt_q;

endmodule

`default_nettype wire

//--- logic/rv_mini_core.sv
// ----------------------------------------
// rv mini core
// in-order RV32I subset pipeline: fetch
// queue, decode, execute and commit
// ----------------------------------------

`timescale 1ns/10ps
`default_nettype none

module rv_mini_core import core_pkg::*; #(
  parameter int unsigned FetchDepth = 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // producer side, credit based
  input  logic      instr_valid_i,
  input  xlen_t     instr_i,
  output logic      instr_credit_o,
  // commit port
  output logic      commit_valid_o,
  output reg_addr_t commit_rd_o,
  output xlen_t     commit_data_o,
  output logic      commit_illegal_o,
  // counters
  output xlen_t     instret_o,
  output xlen_t     illegal_cnt_o
);

  // ----------------------------------------
  // stage wires
  // ----------------------------------------
  logic      head_valid;
  xlen_t     head_instr;
  logic      pop;

  logic      id_valid;
  alu_op_e   id_op;
  reg_addr_t id_rd;
  reg_addr_t id_rs1;
  reg_addr_t id_rs2;
  xlen_t     id_imm;
  logic      id_use_imm;

  reg_addr_t rf_raddr_a;
  reg_addr_t rf_raddr_b;
  xlen_t     rf_rdata_a;
  xlen_t     rf_rdata_b;
  logic      rf_we;
  reg_addr_t rf_waddr;
  xlen_t     rf_wdata;

  logic      res_valid;
  reg_addr_t res_rd;
  xlen_t     res_data;
  logic      res_illegal;

  fetch_queue #(
    .FetchDepth ( FetchDepth )
  ) i_fetch_queue (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .instr_valid_i ( instr_valid_i  ),
    .instr_i       ( instr_i        ),
    .pop_i         ( pop            ),
    .head_valid_o  ( head_valid     ),
    .head_instr_o  ( head_instr     ),
    .credit_o      ( instr_credit_o )
  );

  id_stage i_id_stage (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .head_valid_i ( head_valid ),
    .head_instr_i ( head_instr ),
    .pop_o        ( pop        ),
    .id_valid_o   ( id_valid   ),
    .id_op_o      ( id_op      ),
    .id_rd_o      ( id_rd      ),
    .id_rs1_o     ( id_rs1     ),
    .id_rs2_o     ( id_rs2     ),
    .id_imm_o     ( id_imm     ),
    .id_use_imm_o ( id_use_imm )
  );

  regfile i_regfile (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .raddr_a_i ( rf_raddr_a ),
    .raddr_b_i ( rf_raddr_b ),
    .rdata_a_o ( rf_rdata_a ),
    .rdata_b_o ( rf_rdata_b ),
    .we_i      ( rf_we      ),
    .waddr_i   ( rf_waddr   ),
    .wdata_i   ( rf_wdata   )
  );

  ex_stage i_ex_stage (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .id_valid_i    ( id_valid    ),
    .id_op_i       ( id_op       ),
    .id_rd_i       ( id_rd       ),
    .id_rs1_i      ( id_rs1      ),
    .id_rs2_i      ( id_rs2      ),
    .id_imm_i      ( id_imm      ),
    .id_use_imm_i  ( id_use_imm  ),
    .raddr_a_o     ( rf_raddr_a  ),
    .raddr_b_o     ( rf_raddr_b  ),
    .rdata_a_i     ( rf_rdata_a  ),
    .rdata_b_i     ( rf_rdata_b  ),
    .res_valid_o   ( res_valid   ),
    .res_rd_o      ( res_rd      ),
    .res_data_o    ( res_data    ),
    .res_illegal_o ( res_illegal )
  );

  commit_stage i_commit_stage (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .res_valid_i      ( res_valid        ),
    .res_rd_i         ( res_rd           ),
    .res_data_i       ( res_data         ),
    .res_illegal_i    ( res_illegal      ),
    .we_o             ( rf_we            ),
    .waddr_o          ( rf_waddr         ),
    .wdata_o          ( rf_wdata         ),
    .commit_valid_o   ( commit_valid_o   ),
    .commit_rd_o      ( commit_rd_o      ),
    .commit_data_o    ( commit_data_o    ),
    .commit_illegal_o ( commit_illegal_o ),
    .instret_o        ( instret_o        ),
    .illegal_cnt_o    ( illegal_cnt_o    )
  );

endmodule

`default_nettype wire

//--- bench/tb_rv_mini_core.sv
// ----------------------------------------
// rv mini core testbench
// credit-limited stimulus, ISA reference
// model and in-order commit checks
// ----------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_rv_mini_core import core_pkg::*; ();

  localparam int unsigned FetchDepth = 4;
  // instructions sent by the reset, chain, random, illegal and x0 tests
  localparam int NumInstr   = FetchDepth + 18 + 100 + 20 + 6;
  localparam int CycleLimit = NumInstr * 4 + 100;

  logic      clk_i;
  logic      rst_ni;
  logic      instr_valid_i;
  xlen_t     instr_i;
  logic      instr_credit_o;
  logic      commit_valid_o;
  reg_addr_t commit_rd_o;
  xlen_t     commit_data_o;
  logic      commit_illegal_o;
  xlen_t     instret_o;
  xlen_t     illegal_cnt_o;

  xlen_t     model_regs [NrRegs];
  reg_addr_t exp_rd_q [$];
  xlen_t     exp_data_q [$];
  logic      exp_ill_q [$];
  xlen_t     lcg_state = 32'h353ee7cc;
  int        credits = FetchDepth;
  int        sent = 0;
  int        commits = 0;
  int        returned = 0;
  int        illegal_sent = 0;
  int        errors = 0;
  int        checks = 0;
  int        tests = 0;
  int        test_errs = 0;
  int        cycle_count = 0;

  rv_mini_core #(
    .FetchDepth ( FetchDepth )
  ) i_rv_mini_core (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .instr_valid_i    ( instr_valid_i    ),
    .instr_i          ( instr_i          ),
    .instr_credit_o   ( instr_credit_o   ),
    .commit_valid_o   ( commit_valid_o   ),
    .commit_rd_o      ( commit_rd_o      ),
    .commit_data_o    ( commit_data_o    ),
    .commit_illegal_o ( commit_illegal_o ),
    .instret_o        ( instret_o        ),
    .illegal_cnt_o    ( illegal_cnt_o    )
  );

  always #20 clk_i = ~clk_i;

  // ----------------------------------------
  // checks
  // ----------------------------------------
  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------
  function automatic xlen_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic xlen_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3,
                                  input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OpcodeOp};
  endfunction

  function automatic xlen_t enc_addi(input logic [11:0] imm, input reg_addr_t rs1,
                                     input reg_addr_t rd);
    return {imm, rs1, 3'b000, rd, OpcodeOpImm};
  endfunction

  function automatic xlen_t enc_lui(input logic [19:0] imm, input reg_addr_t rd);
    return {imm, rd, OpcodeLui};
  endfunction

  // registers limited to x0..x7 so hazards and x0 show up often
  function automatic xlen_t random_legal();
    xlen_t     r;
    xlen_t     imm;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    r   = lcg_next();
    imm = lcg_next();
    rd  = {2'b0, r[23:21]};
    rs1 = {2'b0, r[20:18]};
    rs2 = {2'b0, r[17:15]};
    case (r[31:24] % 9)
      0:       return enc_r(7'b0, rs2, rs1, 3'b000, rd);
      1:       return enc_r(Funct7Alt, rs2, rs1, 3'b000, rd);
      2:       return enc_r(7'b0, rs2, rs1, 3'b111, rd);
      3:       return enc_r(7'b0, rs2, rs1, 3'b110, rd);
      4:       return enc_r(7'b0, rs2, rs1, 3'b100, rd);
      5:       return enc_r(7'b0, rs2, rs1, 3'b001, rd);
      6:       return enc_r(7'b0, rs2, rs1, 3'b101, rd);
      7:       return enc_addi(imm[31:20], rs1, rd);
      default: return enc_lui(imm[31:12], rd);
    endcase
  endfunction

  // load opcode, slt and slli are all outside the subset
  function automatic xlen_t random_illegal();
    xlen_t r;
    r = lcg_next();
    case (r[31:24] % 3)
      0:       return {r[24:0], 7'b0000011};
      1:       return enc_r(7'b0, r[12:8], r[17:13], 3'b010, r[22:18]);
      default: return {r[20:4], 3'b001, r[11:7], OpcodeOpImm};
    endcase
  endfunction

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic void ref_model(input xlen_t word, output reg_addr_t rd,
                                    output xlen_t data, output logic illegal);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      a;
    xlen_t      b;
    opcode  = word[6:0];
    funct3  = word[14:12];
    funct7  = word[31:25];
    a       = model_regs[word[19:15]];
    b       = model_regs[word[24:20]];
    rd      = word[11:7];
    data    = '0;
    illegal = 1'b0;
    if (opcode == OpcodeOp && funct7 == 7'b0) begin
      case (funct3)
        3'b000:  data = a + b;
        3'b001:  data = a << b[4:0];
        3'b100:  data = a ^ b;
        3'b101:  data = a >> b[4:0];
        3'b110:  data = a | b;
        3'b111:  data = a & b;
        default: illegal = 1'b1;
      endcase
    end else if (opcode == OpcodeOp && funct7 == Funct7Alt && funct3 == 3'b000) begin
      data = a - b;
    end else if (opcode == OpcodeOpImm && funct3 == 3'b000) begin
      data = a + {{20{word[31]}}, word[31:20]};
    end else if (opcode == OpcodeLui) begin
      data = {word[31:12], 12'b0};
    end else begin
      illegal = 1'b1;
    end
    if (illegal) begin
      rd = '0;
    end
  endfunction

  // ----------------------------------------
  // producer side
  // ----------------------------------------
  task automatic next_cycle();
    @(negedge clk_i);
    instr_valid_i = 1'b0;
    if (instr_credit_o) begin
      credits++;
      returned++;
    end
  endtask

  task automatic send_word(input xlen_t word);
    reg_addr_t rd;
    xlen_t     data;
    logic      ill;
    while (credits == 0) begin
      next_cycle();
    end
    ref_model(word, rd, data, ill);
    if (!ill && rd != '0) begin
      model_regs[rd] = data;
    end
    if (ill) begin
      illegal_sent++;
    end
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(data);
    exp_ill_q.push_back(ill);
    instr_valid_i = 1'b1;
    instr_i       = word;
    credits--;
    sent++;
    next_cycle();
  endtask

  task automatic end_test(input string name);
    while (commits != sent) begin
      next_cycle();
    end
    repeat (2) next_cycle();
    check_word("credits_returned", xlen_t'(returned), xlen_t'(sent));
    check_word("instret_o", instret_o, xlen_t'(sent));
    check_word("illegal_cnt_o", illegal_cnt_o, xlen_t'(illegal_sent));
    tests++;
    $display("test %s done, %0d errors", name, errors - test_errs);
    test_errs = errors;
  endtask

  // ----------------------------------------
  // commit compare
  // ----------------------------------------
  always @(negedge clk_i) begin : compare
    reg_addr_t e_rd;
    xlen_t     e_data;
    logic      e_ill;
    if (rst_ni && commit_valid_o) begin
      if (exp_rd_q.size() == 0) begin
        $display("unexpected commit at %0t ns with no instruction outstanding", $time);
        errors++;
      end else begin
        e_rd   = exp_rd_q.pop_front();
        e_data = exp_data_q.pop_front();
        e_ill  = exp_ill_q.pop_front();
        check_reg("commit_rd_o", commit_rd_o, e_rd);
        check_flag("commit_illegal_o", commit_illegal_o, e_ill);
        if (!e_ill) begin
          check_word("commit_data_o", commit_data_o, e_data);
        end
        commits++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > CycleLimit) begin
      $display("timeout, run exceeded %0d cycles", CycleLimit);
      $display("Something failed");
      $finish;
    end
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin : main
    xlen_t gap;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    for (int i = 0; i < NrRegs; i++) begin
      model_regs[i] = '0;
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // reset values and then one full window of credits
    check_flag("commit_valid_o", commit_valid_o, 1'b0);
    check_flag("instr_credit_o", instr_credit_o, 1'b0);
    check_word("instret_o", instret_o, '0);
    check_word("illegal_cnt_o", illegal_cnt_o, '0);
    for (int i = 1; i <= FetchDepth; i++) begin
      send_word(enc_addi(12'(i * 17), '0, reg_addr_t'(i)));
    end
    end_test("reset");

    // back-to-back dependent chains through the bypass
    send_word(enc_addi(12'd3, 5'd0, 5'd5));
    repeat (8) send_word(enc_r(7'b0, 5'd5, 5'd5, 3'b000, 5'd5));
    send_word(enc_addi(12'hff9, 5'd0, 5'd6));
    for (int i = 0; i < 4; i++) begin
      send_word(enc_r(Funct7Alt, 5'd5, 5'd6, 3'b000, 5'd6));
      send_word(enc_r(7'b0, 5'd6, 5'd5, 3'b100, 5'd5));
    end
    end_test("chain");

    // full rate first and then bursts with gaps
    repeat (60) send_word(random_legal());
    for (int i = 0; i < 40; i++) begin
      send_word(random_legal());
      gap = lcg_next();
      repeat (gap[31:30]) next_cycle();
    end
    end_test("random");

    for (int i = 0; i < 20; i++) begin
      if (i % 2 == 0) begin
        send_word(random_illegal());
      end else begin
        send_word(random_legal());
      end
    end
    end_test("illegal");

    // x0 stays zero even right after an x0 destination
    send_word(enc_addi(12'h055, 5'd0, 5'd1));
    send_word(enc_addi(12'h123, 5'd1, 5'd0));
    send_word(enc_r(7'b0, 5'd1, 5'd0, 3'b000, 5'd7));
    send_word(enc_lui(20'habcde, 5'd0));
    send_word(enc_r(7'b0, 5'd0, 5'd0, 3'b110, 5'd7));
    send_word(enc_r(7'b0, 5'd7, 5'd0, 3'b000, 5'd2));
    end_test("x0");

    check_word("instret_o", instret_o, xlen_t'(NumInstr));
    check_word("illegal_cnt_o", illegal_cnt_o, xlen_t'(illegal_sent));
    tests++;
    $display("test counters done, %0d errors", errors - test_errs);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
logic/core_pkg.sv
logic/fetch_queue.sv
logic/id_stage.sv
logic/regfile.sv
logic/ex_stage.sv
logic/commit_stage.sv
logic/rv_mini_core.sv
bench/tb_rv_mini_core.sv

//--- run.sh
#!/bin/sh
# build and run the rv_mini_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_mini_core -f verilog.f
./obj_dir/Vtb_rv_mini_core | tee sim.log

if grep -q "Everything OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
